// ==== common/dcache_pkg.sv ====
// ==========================================================================
// Shared widths and types of the data cache. Byte addresses, 32-bit words,
// 16-byte lines. The set count is not fixed here but set at the top level.
// ==========================================================================
`default_nettype none

package dcache_pkg;

  // Widths
  localparam int ADDR_W      = 32;
  localparam int WORD_W      = 32;
  localparam int LINE_WORDS  = 4;
  localparam int LINE_W      = WORD_W * LINE_WORDS;
  localparam int OFFSET_BITS = 4;        // Byte offset within a line

  localparam int WORD_BYTES  = WORD_W / 8;
  localparam int LINE_BYTES  = LINE_W / 8;  // One data RAM lane per byte

  // Load/store request, valid for one cycle with lsu_req_valid_i
  typedef struct packed {
    logic                  we;       // Store
    logic [ADDR_W-1:0]     addr;     // Word aligned
    logic [WORD_W-1:0]     wdata;
    logic [WORD_BYTES-1:0] be;       // Byte enables, stores only
  } lsu_req_t;

  // Whole-line memory transfer
  typedef struct packed {
    logic              we;           // Writeback of a victim
    logic [ADDR_W-1:0] addr;         // Line aligned
    logic [LINE_W-1:0] line;         // Ignored on fills
  } mem_req_t;

  // Controller states
  // Hit responses and the cycle after a fill run in IDLE with a pending flag
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,        // Tag compare on the RAM read
    WRITEBACK,     // Dirty victim out
    FILL,          // Line in from memory
    FLUSH_READ,    // RAM read at the flush index
    FLUSH_CHECK,   // Dirty test for that set
    FLUSH_WB       // Writeback, then clean
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== dcache/dcache_sram.sv ====
// ==========================================================================
// Single-port RAM, registered read when en_i is set. A write and a read in
// the same cycle return the old entry. The entry splits into equal lanes.
// ==========================================================================
`default_nettype none

module dcache_sram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 64,
  parameter int  LANES   = 1
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     en_i,      // Read enable
  input  logic [LANES-1:0]         we_i,      // One bit per lane
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  entry_t                   wdata_i,
  output entry_t                   rdata_o
);

  localparam int ENTRY_W = $bits(entry_t);
  localparam int LANE_W  = ENTRY_W / LANES;

  logic [ENTRY_W-1:0] mem_q [DEPTH];
  logic [ENTRY_W-1:0] rdata_q;
  logic [ENTRY_W-1:0] wbits;

  assign wbits = wdata_i;

  // Storage has no reset, contents are qualified by the valid bits outside
  always_ff @(posedge clk) begin
    for (int l = 0; l < LANES; l++) begin
      if (we_i[l]) mem_q[addr_i][l*LANE_W +: LANE_W] <= wbits[l*LANE_W +: LANE_W];
    end
    if (en_i) rdata_q <= mem_q[addr_i];  // Old data on a same-cycle write
  end

  assign rdata_o = entry_t'(rdata_q);

  a_lane_split: assert property (@(posedge clk) disable iff (!rst_n)
    (ENTRY_W % LANES) == 0)
    else $error("entry width %0d not a multiple of %0d lanes", ENTRY_W, LANES);

endmodule

`default_nettype wire

// ==== dcache/dcache_datapath.sv ====
// ==========================================================================
// Cache datapath. Owns the hit and dirty decisions, the controller only
// sequences. After a fill the first access sees the line from a register.
// ==========================================================================
`default_nettype none

module dcache_datapath #(
  parameter int NUM_SETS = 64
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              lsu_req_valid_i,
  input  dcache_pkg::lsu_req_t              lsu_req_i,
  input  logic                              latch_req_i,
  input  logic                              lookup_i,
  input  logic                              store_hit_i,
  input  logic                              fill_wr_i,
  input  logic                              clean_wr_i,
  input  logic                              use_flush_idx_i,
  input  logic [$clog2(NUM_SETS)-1:0]       flush_idx_i,
  input  logic                              wb_sel_i,
  input  logic [dcache_pkg::LINE_W-1:0]     mem_rdata_i,
  output logic                              hit_o,
  output logic                              victim_dirty_o,
  output logic [dcache_pkg::WORD_W-1:0]     lsu_rdata_o,
  output logic [dcache_pkg::ADDR_W-1:0]     mem_addr_o,
  output logic [dcache_pkg::LINE_W-1:0]     mem_line_o
);

  import dcache_pkg::*;

  localparam int IDX_W  = $clog2(NUM_SETS);
  localparam int TAG_W  = ADDR_W - IDX_W - OFFSET_BITS;
  localparam int WOFF_W = $clog2(LINE_WORDS);

  // Tag width follows the set count, so the entry is local
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             dirty;
  } tag_entry_t;

  lsu_req_t            req_q;
  logic [NUM_SETS-1:0] valid_q;
  logic                fresh_q;           // Fill line held in fill_line_q
  logic [LINE_W-1:0]   fill_line_q;

  logic [TAG_W-1:0]    tag_q;
  logic [IDX_W-1:0]    idx_q;
  logic [WOFF_W-1:0]   word_off;
  logic [IDX_W-1:0]    ram_idx;
  logic [IDX_W-1:0]    vic_idx;

  logic [LINE_W-1:0]     data_rd;
  logic [LINE_W-1:0]     cur_line;
  logic [LINE_W-1:0]     merged_line;
  logic [LINE_W-1:0]     data_wdata;
  logic [LINE_BYTES-1:0] lane_mask;
  logic [LINE_BYTES-1:0] data_we;
  tag_entry_t            tag_rd;
  tag_entry_t            tag_wdata;
  logic [0:0]            tag_we;

  // Request capture, payload only
  always_ff @(posedge clk) begin
    if (latch_req_i) req_q <= lsu_req_i;
    if (fill_wr_i) fill_line_q <= mem_rdata_i;
  end

  assign tag_q    = req_q.addr[ADDR_W-1 -: TAG_W];
  assign idx_q    = req_q.addr[OFFSET_BITS +: IDX_W];
  assign word_off = req_q.addr[OFFSET_BITS-1 -: WOFF_W];

  // New request addresses the RAMs directly in its own cycle
  assign ram_idx = use_flush_idx_i ? flush_idx_i :
                   lsu_req_valid_i ? lsu_req_i.addr[OFFSET_BITS +: IDX_W] : idx_q;
  assign vic_idx = use_flush_idx_i ? flush_idx_i : idx_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      fresh_q <= 1'b0;
    end else begin
      if (fill_wr_i) valid_q[idx_q] <= 1'b1;
      if (fill_wr_i) fresh_q <= 1'b1;
      else if (latch_req_i || use_flush_idx_i) fresh_q <= 1'b0;
    end
  end

  assign cur_line = fresh_q ? fill_line_q : data_rd;

  // Store bytes into the current line, one lane per byte
  always_comb begin
    int lane;
    merged_line = cur_line;
    lane_mask   = '0;
    for (int b = 0; b < WORD_BYTES; b++) begin
      lane = int'(word_off) * WORD_BYTES + b;
      if (req_q.be[b]) begin
        merged_line[lane*8 +: 8] = req_q.wdata[b*8 +: 8];
        lane_mask[lane]          = 1'b1;
      end
    end
  end

  assign data_wdata = fill_wr_i ? mem_rdata_i : merged_line;
  assign data_we    = fill_wr_i ? '1 : (store_hit_i ? lane_mask : '0);

  always_comb begin
    tag_wdata = '{tag: tag_q, dirty: 1'b0};  // Fill writes a clean line
    tag_we    = 1'b0;
    if (fill_wr_i) begin
      tag_we = 1'b1;
    end else if (store_hit_i) begin
      tag_wdata.dirty = 1'b1;
      tag_we          = 1'b1;
    end else if (clean_wr_i) begin
      tag_wdata.tag = tag_rd.tag;            // Flush keeps the line valid
      tag_we        = 1'b1;
    end
  end

  dcache_sram #(.entry_t(logic [LINE_W-1:0]), .DEPTH(NUM_SETS), .LANES(LINE_BYTES)) data_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (lookup_i),
    .we_i    (data_we),
    .addr_i  (ram_idx),
    .wdata_i (data_wdata),
    .rdata_o (data_rd)
  );

  dcache_sram #(.entry_t(tag_entry_t), .DEPTH(NUM_SETS), .LANES(1)) tag_ram (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (lookup_i),
    .we_i    (tag_we),
    .addr_i  (ram_idx),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rd)
  );

  assign hit_o          = fresh_q || (valid_q[idx_q] && tag_rd.tag == tag_q);
  assign victim_dirty_o = valid_q[vic_idx] && tag_rd.dirty;
  assign lsu_rdata_o    = cur_line[word_off*WORD_W +: WORD_W];

  // Victim line for writeback, requested line for fill
  assign mem_addr_o = wb_sel_i ? {tag_rd.tag, vic_idx, {OFFSET_BITS{1'b0}}}
                               : {tag_q, idx_q, {OFFSET_BITS{1'b0}}};
  assign mem_line_o = data_rd;

  a_store_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
    store_hit_i |-> hit_o)
    else $error("store write without a hit");

endmodule

`default_nettype wire

// ==== dcache/dcache_controller.sv ====
// ==========================================================================
// Cache sequencer. Hit load answers in LOOKUP, hit store and post-fill
// responses take one more cycle in IDLE. One memory transfer at a time.
// ==========================================================================
`default_nettype none

module dcache_controller #(
  parameter int NUM_SETS = 64
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        lsu_req_valid_i,
  input  logic                        req_we_i,
  input  logic                        flush_i,
  input  logic                        hit_i,
  input  logic                        victim_dirty_i,
  input  logic                        mem_done_i,
  output logic                        latch_req_o,
  output logic                        lookup_o,
  output logic                        store_hit_o,
  output logic                        fill_wr_o,
  output logic                        clean_wr_o,
  output logic                        use_flush_idx_o,
  output logic [$clog2(NUM_SETS)-1:0] flush_idx_o,
  output logic                        wb_sel_o,
  output logic                        mem_req_valid_o,
  output logic                        mem_we_o,
  output logic                        lsu_rsp_valid_o,
  output logic                        flush_done_o
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(NUM_SETS);

  ctrl_state_t      state_q, state_d;
  logic [IDX_W-1:0] flush_idx_q, flush_idx_d;
  logic             pend_q, pend_d;        // Response cycle due
  logic             busy_q;                // Memory transfer outstanding
  logic             done_q, done_d;
  logic             we_q;
  logic             step_set;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      flush_idx_q <= '0;
      pend_q      <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      state_q     <= state_d;
      flush_idx_q <= flush_idx_d;
      pend_q      <= pend_d;
      done_q      <= done_d;
      if (mem_req_valid_o) busy_q <= 1'b1;
      else if (mem_done_i) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (latch_req_o) we_q <= req_we_i;
  end

  always_comb begin
    state_d         = state_q;
    flush_idx_d     = flush_idx_q;
    pend_d          = 1'b0;
    done_d          = 1'b0;
    step_set        = 1'b0;
    latch_req_o     = 1'b0;
    lookup_o        = 1'b0;
    store_hit_o     = 1'b0;
    fill_wr_o       = 1'b0;
    clean_wr_o      = 1'b0;
    use_flush_idx_o = 1'b0;
    wb_sel_o        = 1'b0;
    mem_we_o        = 1'b0;
    lsu_rsp_valid_o = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (pend_q) begin
          lsu_rsp_valid_o = 1'b1;
          store_hit_o     = we_q;
        end else if (lsu_req_valid_i) begin
          latch_req_o = 1'b1;
          lookup_o    = 1'b1;
          state_d     = LOOKUP;
        end else if (flush_i) begin
          flush_idx_d = '0;
          state_d     = FLUSH_READ;
        end
      end
      LOOKUP: begin
        if (hit_i) begin
          lsu_rsp_valid_o = !we_q;  // Stores write next cycle
          pend_d          = we_q;
          state_d         = IDLE;
        end else begin
          state_d = victim_dirty_i ? WRITEBACK : FILL;
        end
      end
      WRITEBACK: begin
        wb_sel_o = 1'b1;
        mem_we_o = 1'b1;
        if (mem_done_i) state_d = FILL;
      end
      FILL: begin
        if (mem_done_i) begin
          fill_wr_o = 1'b1;
          pend_d    = 1'b1;
          state_d   = IDLE;
        end
      end
      FLUSH_READ: begin
        use_flush_idx_o = 1'b1;
        lookup_o        = 1'b1;
        state_d         = FLUSH_CHECK;
      end
      FLUSH_CHECK: begin
        use_flush_idx_o = 1'b1;
        if (victim_dirty_i) state_d = FLUSH_WB;
        else step_set = 1'b1;
      end
      FLUSH_WB: begin
        use_flush_idx_o = 1'b1;
        wb_sel_o        = 1'b1;
        mem_we_o        = 1'b1;
        if (mem_done_i) begin
          clean_wr_o = 1'b1;
          step_set   = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase

    // Advance the flush walk
    if (step_set) begin
      if (flush_idx_q == IDX_W'(NUM_SETS - 1)) begin
        done_d  = 1'b1;
        state_d = IDLE;
      end else begin
        flush_idx_d = flush_idx_q + 1'b1;
        state_d     = FLUSH_READ;
      end
    end
  end

  // First cycle of a transfer state only
  assign mem_req_valid_o = (state_q inside {WRITEBACK, FILL, FLUSH_WB}) && !busy_q;
  assign flush_idx_o     = flush_idx_q;
  assign flush_done_o    = done_q;

  a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_req_valid_i || flush_i) |-> (state_q == IDLE && !pend_q))
    else $error("request or flush while cache busy");

  a_done_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    mem_done_i |-> busy_q)
    else $error("memory done without a request");

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
// ==========================================================================
// Write-back direct-mapped data cache. One request in flight, no stalls;
// memory moves whole lines and answers each request once.
// ==========================================================================
`default_nettype none

module dcache_top #(
  parameter int NUM_SETS = 64
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          lsu_req_valid_i,
  input  dcache_pkg::lsu_req_t          lsu_req_i,
  input  logic                          flush_i,
  output logic                          lsu_rsp_valid_o,
  output logic [dcache_pkg::WORD_W-1:0] lsu_rdata_o,
  output logic                          flush_done_o,
  output logic                          mem_req_valid_o,
  output dcache_pkg::mem_req_t          mem_req_o,
  input  logic                          mem_done_i,
  input  logic [dcache_pkg::LINE_W-1:0] mem_rdata_i
);

  import dcache_pkg::*;

  localparam int IDX_W = $clog2(NUM_SETS);

  logic              latch_req;
  logic              lookup;
  logic              store_hit;
  logic              fill_wr;
  logic              clean_wr;
  logic              use_flush_idx;
  logic [IDX_W-1:0]  flush_idx;
  logic              wb_sel;
  logic              hit;
  logic              victim_dirty;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  logic [LINE_W-1:0] mem_line;

  dcache_controller #(.NUM_SETS(NUM_SETS)) ctrl0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .lsu_req_valid_i (lsu_req_valid_i),
    .req_we_i        (lsu_req_i.we),     // Latched with the request
    .flush_i         (flush_i),
    .hit_i           (hit),
    .victim_dirty_i  (victim_dirty),
    .mem_done_i      (mem_done_i),
    .latch_req_o     (latch_req),
    .lookup_o        (lookup),
    .store_hit_o     (store_hit),
    .fill_wr_o       (fill_wr),
    .clean_wr_o      (clean_wr),
    .use_flush_idx_o (use_flush_idx),
    .flush_idx_o     (flush_idx),
    .wb_sel_o        (wb_sel),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_we_o        (mem_we),
    .lsu_rsp_valid_o (lsu_rsp_valid_o),
    .flush_done_o    (flush_done_o)
  );

  dcache_datapath #(.NUM_SETS(NUM_SETS)) dp0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_i       (lsu_req_i),
    .latch_req_i     (latch_req),
    .lookup_i        (lookup),
    .store_hit_i     (store_hit),
    .fill_wr_i       (fill_wr),
    .clean_wr_i      (clean_wr),
    .use_flush_idx_i (use_flush_idx),
    .flush_idx_i     (flush_idx),
    .wb_sel_i        (wb_sel),
    .mem_rdata_i     (mem_rdata_i),
    .hit_o           (hit),
    .victim_dirty_o  (victim_dirty),
    .lsu_rdata_o     (lsu_rdata_o),
    .mem_addr_o      (mem_addr),
    .mem_line_o      (mem_line)
  );

  assign mem_req_o = '{we: mem_we, addr: mem_addr, line: mem_line};

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// ==========================================================================
// Free-running testbench clock and a synchronous active-low reset that is
// released on a rising edge after RESET_CYCLES cycles.
// ==========================================================================
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                       // Released on a rising edge
  end

endmodule

`default_nettype wire

// ==== bench/dcache_tb.sv ====
// ==========================================================================
// Data cache testbench with 4 sets over 64 lines of backing memory at
// MEM_BASE. Memory answers after 1 to 6 cycles. Stops at the first error.
// ==========================================================================
`default_nettype none

module dcache_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  localparam int                NUM_SETS   = 4;     // Few sets for frequent conflicts
  localparam int                MEM_LINES  = 64;
  localparam int                MEM_WORDS  = MEM_LINES * LINE_WORDS;
  localparam logic [ADDR_W-1:0] MEM_BASE   = 32'h0000_4000;
  localparam logic [ADDR_W-1:0] MEM_END    = MEM_BASE + 32'(MEM_WORDS * WORD_BYTES);
  localparam int                NUM_RANDOM = 1500;
  localparam int                LAT_TAB    = 512;
  localparam int unsigned       SEED       = 32'hb3c8f8a2;
  // Worst access about 20 cycles plus flushes and reset
  localparam int                TIMEOUT_CYCLES = 40000;

  typedef struct packed {
    logic              is_load;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
  } expect_t;

  logic              clk;
  logic              rst_n;
  logic              lsu_req_valid;
  lsu_req_t          lsu_req;
  logic              flush;
  logic              lsu_rsp_valid;
  logic [WORD_W-1:0] lsu_rdata;
  logic              flush_done;
  logic              mem_req_valid;
  mem_req_t          mem_req;
  logic              mem_done;
  logic [LINE_W-1:0] mem_rdata;

  logic [WORD_W-1:0] shadow_mem [MEM_WORDS];   // Reference contents
  logic [WORD_W-1:0] back_mem   [MEM_WORDS];   // Backing memory model
  int                lat_tab    [LAT_TAB];
  expect_t           exp_q      [$];
  bit                started;                  // First request issued
  logic              mem_busy;
  int                mem_req_cnt;
  int                mem_wr_cnt;
  int                cycle_cnt;

  clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(16)) clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dcache_top #(.NUM_SETS(NUM_SETS)) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .lsu_req_valid_i (lsu_req_valid),
    .lsu_req_i       (lsu_req),
    .flush_i         (flush),
    .lsu_rsp_valid_o (lsu_rsp_valid),
    .lsu_rdata_o     (lsu_rdata),
    .flush_done_o    (flush_done),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_o       (mem_req),
    .mem_done_i      (mem_done),
    .mem_rdata_i     (mem_rdata)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  // Start pattern that depends on every address bit
  function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  // Applies a store by byte enables and returns the word after the access
  function automatic logic [WORD_W-1:0] ref_load(input lsu_req_t req);
    int                wi;
    logic [WORD_W-1:0] w;
    wi = int'((req.addr - MEM_BASE) >> 2);
    w  = shadow_mem[wi];
    if (req.we) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (req.be[b]) w[b*8 +: 8] = req.wdata[b*8 +: 8];
      end
      shadow_mem[wi] = w;
    end
    return w;
  endfunction

  function automatic logic [LINE_W-1:0] shadow_line(input int first_word);
    logic [LINE_W-1:0] line;
    for (int w = 0; w < LINE_WORDS; w++) line[w*WORD_W +: WORD_W] = shadow_mem[first_word + w];
    return line;
  endfunction

  // One load or store that returns the cycles from request to response
  task automatic access(input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [WORD_W-1:0] wdata, input logic [WORD_BYTES-1:0] be,
                        output int latency);
    lsu_req_t req;
    expect_t  e;
    int       lat;
    req       = '{we: we, addr: addr, wdata: we ? wdata : '0, be: we ? be : '0};
    e.is_load = !we;
    e.addr    = addr;
    e.data    = ref_load(req);
    exp_q.push_back(e);
    @(posedge clk);
    started = 1'b1;
    lsu_req_valid <= 1'b1;
    lsu_req       <= req;
    @(posedge clk);
    lsu_req_valid <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!lsu_rsp_valid);
    latency = lat;
  endtask

  task automatic do_flush();
    @(posedge clk);
    started = 1'b1;
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    do @(negedge clk); while (!flush_done);
  endtask

  task automatic check_backing();
    for (int i = 0; i < MEM_WORDS; i++) begin
      assert (back_mem[i] === shadow_mem[i])
        else fail_now($sformatf("Error: back_mem at %h = %h, expected %h",
                                MEM_BASE + 32'(i * WORD_BYTES), back_mem[i], shadow_mem[i]));
    end
  endtask

  // Comparator for every response
  always @(negedge clk) begin : response_check
    expect_t e;
    if (rst_n && lsu_rsp_valid) begin
      assert (exp_q.size() > 0) else fail_now("A response came with no request outstanding");
      e = exp_q.pop_front();
      if (e.is_load) begin
        assert (lsu_rdata === e.data)
          else fail_now($sformatf("Error: lsu_rdata_o = %h, expected %h at address %h",
                                  lsu_rdata, e.data, e.addr));
      end
    end
  end

  always @(negedge clk) begin : strobe_monitor
    if (rst_n && !started) begin
      assert (!(lsu_rsp_valid || mem_req_valid || flush_done))
        else fail_now("A cache strobe came out before the first request");
    end
    if (rst_n && mem_req_valid) begin
      assert (!mem_busy) else fail_now("A memory request came while one was outstanding");
    end
  end

  // Backing memory with whole lines and one request at a time
  initial begin : mem_model
    mem_req_t          req;
    int                first;
    int                lat;
    logic [LINE_W-1:0] rd_line;
    mem_done    = 1'b0;
    mem_rdata   = '0;
    mem_busy    = 1'b0;
    mem_req_cnt = 0;
    mem_wr_cnt  = 0;
    for (int i = 0; i < MEM_WORDS; i++) back_mem[i] = init_word(MEM_BASE + 32'(i * WORD_BYTES));
    forever begin
      @(negedge clk);
      if (rst_n && mem_req_valid) begin
        req = mem_req;
        assert (req.addr[OFFSET_BITS-1:0] == '0)
          else fail_now($sformatf("Error: mem_req_o.addr = %h, not line aligned", req.addr));
        assert (req.addr >= MEM_BASE && req.addr < MEM_END)
          else fail_now($sformatf("Error: mem_req_o.addr = %h, outside %h to %h",
                                  req.addr, MEM_BASE, MEM_END));
        first = int'((req.addr - MEM_BASE) >> 2);
        if (req.we) begin
          assert (req.line === shadow_line(first))
            else fail_now($sformatf("Error: mem_req_o.line = %h, expected %h",
                                    req.line, shadow_line(first)));
          for (int w = 0; w < LINE_WORDS; w++) back_mem[first + w] = req.line[w*WORD_W +: WORD_W];
          mem_wr_cnt++;
        end
        for (int w = 0; w < LINE_WORDS; w++) rd_line[w*WORD_W +: WORD_W] = back_mem[first + w];
        lat = lat_tab[mem_req_cnt % LAT_TAB];
        mem_req_cnt++;
        mem_busy <= 1'b1;
        repeat (lat) @(posedge clk);
        mem_done  <= 1'b1;
        mem_rdata <= req.we ? '0 : rd_line;
        @(posedge clk);
        mem_done <= 1'b0;
        mem_busy <= 1'b0;                  // Outstanding through the done cycle
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    fail_now("The run did not finish within the cycle limit");
  end

  initial begin : stimulus
    int                lat;
    int                line;
    int                word;
    logic              we;
    logic [ADDR_W-1:0] addr_a;
    int                req_before;
    int                wr_before;
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    flush         = 1'b0;
    started       = 1'b0;
    line          = 0;
    for (int i = 0; i < MEM_WORDS; i++) shadow_mem[i] = init_word(MEM_BASE + 32'(i * WORD_BYTES));
    void'($urandom(SEED));
    for (int i = 0; i < LAT_TAB; i++) lat_tab[i] = $urandom_range(1, 6);

    wait (rst_n);
    repeat (10) @(posedge clk);           // Quiet outputs checked meanwhile

    // Repeated accesses to one line hit with fixed latency
    addr_a = MEM_BASE + 32'h24;
    access(1'b0, addr_a, '0, '0, lat);     // Miss and fill
    req_before = mem_req_cnt;
    access(1'b0, addr_a, '0, '0, lat);
    assert (lat == 1)
      else fail_now($sformatf("Error: lsu_rsp_valid_o after %0h cycles on a load hit, expected 1",
                              lat));
    access(1'b1, addr_a, 32'hdead_beef, 4'hf, lat);
    assert (lat == 2)
      else fail_now($sformatf("Error: lsu_rsp_valid_o after %0h cycles on a store hit, expected 2",
                              lat));
    access(1'b1, addr_a + 32'h4, 32'h1234_5678, 4'b0101, lat);
    assert (lat == 2)
      else fail_now($sformatf("Error: lsu_rsp_valid_o after %0h cycles on a store hit, expected 2",
                              lat));
    access(1'b0, addr_a, '0, '0, lat);
    assert (lat == 1)
      else fail_now($sformatf("Error: lsu_rsp_valid_o after %0h cycles on a load hit, expected 1",
                              lat));
    assert (mem_req_cnt == req_before)
      else fail_now($sformatf("Error: mem_req_valid_o strobes on hits = %0h, expected 0",
                              mem_req_cnt - req_before));

    // Random traffic where half the accesses stay on the last line
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (i == NUM_RANDOM / 2) begin
        do_flush();
        check_backing();
      end
      if ($urandom_range(0, 1) == 0) line = $urandom_range(0, MEM_LINES - 1);
      word = $urandom_range(0, LINE_WORDS - 1);
      we   = 1'($urandom_range(0, 1));
      access(we, MEM_BASE + 32'(line * LINE_BYTES + word * WORD_BYTES), $urandom,
             4'($urandom_range(1, 15)), lat);
    end

    do_flush();
    check_backing();
    wr_before = mem_wr_cnt;
    do_flush();                            // Lines are clean now
    assert (mem_wr_cnt == wr_before)
      else fail_now($sformatf("Error: mem_req_o writebacks in second flush = %0h, expected 0",
                              mem_wr_cnt - wr_before));
    check_backing();

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/dcache_pkg.sv
dcache/dcache_sram.sv
dcache/dcache_datapath.sv
dcache/dcache_controller.sv
design/dcache_top.sv
bench/clk_gen.sv
bench/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dcache_tb
FILELIST  := src.f
BUILD_DIR := obj_dir

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
